// ==== scsi_target.f ====
source/scsi_pkg.sv
source/scsi_cmd_if.sv
source/scsi_xfer_if.sv
source/scsi_cmd_decoder.sv
source/scsi_phase_ctrl.sv
source/scsi_reply_gen.sv
source/scsi_sector_buffer.sv
source/scsi_target.sv
testbench/tb_clock_gen.sv
testbench/scsi_target_tb.sv

// ==== Bender.yml ====
package:
  name: scsi_target

sources:
  - files:
      - source/scsi_pkg.sv
      - source/scsi_cmd_if.sv
      - source/scsi_xfer_if.sv
      - source/scsi_cmd_decoder.sv
      - source/scsi_phase_ctrl.sv
      - source/scsi_reply_gen.sv
      - source/scsi_sector_buffer.sv
      - source/scsi_target.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/scsi_target_tb.sv

// ==== testbench/scsi_patterns.txt ====
// 64 words per record: sel mask, cdb length, status, data kind (0 none 1 listed 2 read 3 write),
// data length, lba count, lba 0, lba 1, ten cdb bytes, then listed data bytes
// select with id 0 only, then test unit ready
@000 01 6 00 0 0 0 0 0 00 00 00 00 00 00 00 00 00 00
@040 08 6 00 0 0 0 0 0 00 00 00 00 00 00 00 00 00 00
// unknown opcode 03
@080 08 6 02 0 0 0 0 0 03 00 00 00 00 00 00 00 00 00
// inquiry, 36 bytes
@0c0 08 6 00 1 24 0 0 0 12 00 00 00 24 00 00 00 00 00
00 00 00 00 20 00 00 00 20 53 45 41 47 41 54 45
20 20 20 20 20 20 20 20 20 20 53 54 32 32 35 4e
00 00 00 00
// read capacity with 1000 blocks mounted
@100 08 a 00 1 8 0 0 0 25 00 00 00 00 00 00 00 00 00
00 00 04 47 00 00 02 00
// mode sense, 12 bytes
@140 08 6 00 1 c 0 0 0 1a 00 00 00 0c 00 00 00 00 00
00 00 00 08 00 00 04 48 00 00 02 00
// read(10) two blocks at 10, write(6) one block at 5
@180 08 a 00 2 400 2 10 11 28 00 00 00 00 10 00 00 02 00
@1c0 08 6 00 3 200 1 5 0 0a 00 00 05 01 00 00 00 00 00
// end of list
@200 00

// ==== testbench/scsi_target_tb.sv ====
/*
 * testbench for the scsi disk target
 * initiator side bus handshake with random ack delays
 * I/O controller model for block reads and writes
 * pattern records from scsi_patterns.txt, compare tasks, timeout counter
 */
`timescale 1ns/10ps

module scsi_target_tb;
	import scsi_pkg::*;

	localparam int unsigned TARGET_ID = 3;
	// words per record in the pattern file
	localparam int REC_WORDS = 64;
	localparam int MAX_RECORDS = 16;

	logic        clk;
	logic        rst;
	logic        sel;
	logic        atn;
	logic        ack;
	logic [7:0]  din;
	logic        bsy;
	logic        msg;
	logic        cd;
	logic        io;
	logic        req;
	logic [7:0]  dout;
	logic        img_mounted;
	logic [23:0] img_blocks;
	logic        io_ack;
	logic [8:0]  sd_buff_addr;
	logic [7:0]  sd_buff_dout;
	logic        sd_buff_wr;
	logic [31:0] io_lba;
	logic        io_rd;
	logic        io_wr;
	logic [7:0]  sd_buff_din;

	logic [31:0] pat [REC_WORDS*MAX_RECORDS];
	// block addresses seen on io_rd / io_wr during one record
	lba_t        lba_seen [$];
	logic [7:0]  wr_data [4096];
	int          wr_blocks;
	int unsigned cycles = 0;
	int unsigned limit = 0;

	tb_clock_gen u_clk (
		.clk(clk),
		.rst(rst)
	);

	scsi_target #(
		.TARGET_ID(TARGET_ID)
	) UUT (
		.clk         (clk),
		.rst         (rst),
		.sel         (sel),
		.atn         (atn),
		.ack         (ack),
		.din         (din),
		.bsy         (bsy),
		.msg         (msg),
		.cd          (cd),
		.io          (io),
		.req         (req),
		.dout        (dout),
		.img_mounted (img_mounted),
		.img_blocks  (img_blocks),
		.io_ack      (io_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr  (sd_buff_wr),
		.io_lba      (io_lba),
		.io_rd       (io_rd),
		.io_wr       (io_wr),
		.sd_buff_din (sd_buff_din)
	);

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_byte(input logic [7:0] expected, input logic [7:0] actual,
		input string what);
		if (actual !== expected) begin
			$display("Error at time %0t: %s expected %02h, got %02h", $time, what,
				expected, actual);
			abort_run();
		end
	endtask

	task automatic check_status(input status_t expected, input status_t actual);
		if (actual !== expected) begin
			$display("Error at time %0t: status expected %02h, got %02h", $time,
				expected, actual);
			abort_run();
		end
	endtask

	task automatic check_lba(input lba_t expected, input lba_t actual);
		if (actual !== expected) begin
			$display("Error at time %0t: io_lba expected %08h, got %08h", $time,
				expected, actual);
			abort_run();
		end
	endtask

	// bsy, msg, cd, io as the initiator expects them in each phase
	function automatic logic [3:0] expected_lines(input phase_t ph);
		case (ph)
			IDLE: return 4'b0000;
			CMD_IN: return 4'b1010;
			DATA_OUT: return 4'b1001;
			DATA_IN: return 4'b1000;
			STATUS_OUT: return 4'b1011;
			default: return 4'b1111;
		endcase
	endfunction

	task automatic verify_phase(input phase_t ph);
		logic [3:0] lines;
		lines = {bsy, msg, cd, io};
		if (lines !== expected_lines(ph)) begin
			$display("Error at time %0t: bsy/msg/cd/io %b in %s, expected %b", $time,
				lines, ph.name(), expected_lines(ph));
			abort_run();
		end
	endtask

	// one req / ack handshake byte starting on a falling edge
	task automatic transfer_byte(input phase_t ph, input logic [7:0] to_dut,
		output logic [7:0] from_dut);
		int unsigned delay;
		while (!req) @(negedge clk);
		verify_phase(ph);
		from_dut = dout;
		delay = $urandom % 6;
		repeat (delay) @(negedge clk);
		din = to_dut;
		ack = 1'b1;
		@(negedge clk);
		// req drops while ack is up, then ack goes away
		while (req) @(negedge clk);
		ack = 1'b0;
	endtask

	task automatic run_record(input int base);
		logic [7:0] mask;
		logic [7:0] got;
		logic [7:0] exp;
		int         n_cdb;
		int         kind;
		int         n_data;
		int         n_lba;
		lba_t       first_lba;
		mask = pat[base][7:0];
		n_cdb = pat[base + 1];
		kind = pat[base + 3];
		n_data = pat[base + 4];
		n_lba = pat[base + 5];
		first_lba = pat[base + 6];
		lba_seen.delete();
		wr_blocks = 0;
		sel = 1'b1;
		din = mask;
		if (!mask[TARGET_ID]) begin
			// another id is addressed so the target stays off the bus
			repeat (16) begin
				@(negedge clk);
				verify_phase(IDLE);
			end
			sel = 1'b0;
			din = 8'h00;
		end else begin
			while (!bsy) @(negedge clk);
			sel = 1'b0;
			din = 8'h00;
			for (int i = 0; i < n_cdb; i++) begin
				transfer_byte(CMD_IN, pat[base + 8 + i][7:0], got);
			end
			for (int i = 0; i < n_data; i++) begin
				case (kind)
					1: begin
						transfer_byte(DATA_OUT, 8'h00, got);
						check_byte(pat[base + 18 + i][7:0], got, "reply byte");
					end
					2: begin
						// controller fills each byte with block address plus offset
						exp = 8'(first_lba + lba_t'(i / BLOCK_BYTES) + lba_t'(i % BLOCK_BYTES));
						transfer_byte(DATA_OUT, 8'h00, got);
						check_byte(exp, got, "sector byte");
					end
					default: begin
						wr_data[i] = 8'($urandom);
						transfer_byte(DATA_IN, wr_data[i], got);
					end
				endcase
			end
			transfer_byte(STATUS_OUT, 8'h00, got);
			check_status(status_t'(pat[base + 2][7:0]), status_t'(got));
			transfer_byte(MESSAGE_OUT, 8'h00, got);
			// command complete message
			check_byte(8'h00, got, "message byte");
			while (bsy) @(negedge clk);
			verify_phase(IDLE);
		end
		if (lba_seen.size() != n_lba) begin
			$display("Error at time %0t: %0d block requests, expected %0d", $time,
				lba_seen.size(), n_lba);
			abort_run();
		end
		for (int k = 0; k < n_lba; k++) begin
			check_lba(pat[base + 6 + k], lba_seen[k]);
		end
	endtask

	// I/O controller model serving one block per request before its ack
	initial begin : io_controller
		forever begin
			@(negedge clk);
			if (io_rd) begin
				lba_seen.push_back(io_lba);
				for (int a = 0; a < BLOCK_BYTES; a++) begin
					sd_buff_addr = 9'(a);
					sd_buff_dout = 8'(io_lba + lba_t'(a));
					sd_buff_wr = 1'b1;
					@(negedge clk);
				end
				sd_buff_wr = 1'b0;
				io_ack = 1'b1;
				@(negedge clk);
				io_ack = 1'b0;
			end else if (io_wr) begin
				lba_seen.push_back(io_lba);
				// sd_buff_din follows the address one cycle later
				for (int a = 0; a < BLOCK_BYTES; a++) begin
					sd_buff_addr = 9'(a);
					@(negedge clk);
					check_byte(wr_data[wr_blocks*BLOCK_BYTES + a], sd_buff_din, "write data");
				end
				wr_blocks++;
				io_ack = 1'b1;
				@(negedge clk);
				io_ack = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if ((limit != 0) && (cycles > limit)) begin
			$display("the run timed out after %0d clock cycles", cycles);
			abort_run();
		end
	end

	initial begin
		int n_rec;
		sel = 1'b0;
		atn = 1'b0;
		ack = 1'b0;
		din = 8'h00;
		img_mounted = 1'b0;
		img_blocks = 24'd0;
		io_ack = 1'b0;
		sd_buff_addr = 9'd0;
		sd_buff_dout = 8'h00;
		sd_buff_wr = 1'b0;
		void'($urandom(32'hf7bd_fc33));
		$readmemh("testbench/scsi_patterns.txt", pat);
		// a zero select mask ends the list
		n_rec = 0;
		while ((n_rec < MAX_RECORDS) && (pat[n_rec*REC_WORDS] != 32'd0)) begin
			n_rec++;
		end
		limit = n_rec * 1200 * 20;
		@(negedge clk);
		while (rst) @(negedge clk);
		img_blocks = 24'd1000;
		img_mounted = 1'b1;
		@(negedge clk);
		img_mounted = 1'b0;
		for (int r = 0; r < n_rec; r++) begin
			run_record(r * REC_WORDS);
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== testbench/tb_clock_gen.sv ====
/*
 * clock and reset source for the testbench
 * 4 ns clock, reset held for eight cycles
 */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// release on a falling edge so the first active edge sees a clean low
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== source/scsi_target.sv ====
/*
 * scsi disk target top level
 * phase controller, command decoder, reply tables and sector buffer
 * joined over the command and transfer interfaces
 */
`timescale 1ns/10ps

module scsi_target #(
	parameter int unsigned TARGET_ID = 0
) (
	input  logic        clk,
	input  logic        rst,
	// scsi bus, target side
	input  logic        sel,
	// atn is accepted, initiator messages are not supported
	input  logic        atn,
	input  logic        ack,
	input  logic [7:0]  din,
	output logic        bsy,
	output logic        msg,
	output logic        cd,
	output logic        io,
	output logic        req,
	output logic [7:0]  dout,
	// image and I/O controller side
	input  logic        img_mounted,
	input  logic [23:0] img_blocks,
	input  logic        io_ack,
	input  logic [8:0]  sd_buff_addr,
	input  logic [7:0]  sd_buff_dout,
	input  logic        sd_buff_wr,
	output logic [31:0] io_lba,
	output logic        io_rd,
	output logic        io_wr,
	output logic [7:0]  sd_buff_din
);

	scsi_cmd_if cmd_bus ();
	scsi_xfer_if xfer_bus ();

	scsi_phase_ctrl #(
		.TARGET_ID(TARGET_ID)
	) u_phase (
		.clk (clk),
		.rst (rst),
		.sel (sel),
		.din (din),
		.ack (ack),
		.bsy (bsy),
		.msg (msg),
		.cd  (cd),
		.io  (io),
		.req (req),
		.dout(dout),
		.cmd (cmd_bus.phase),
		.xfer(xfer_bus.phase)
	);

	scsi_cmd_decoder u_decoder (
		.clk(clk),
		.rst(rst),
		.cmd(cmd_bus.decoder)
	);

	scsi_reply_gen u_reply (
		.clk        (clk),
		.img_mounted(img_mounted),
		.img_blocks (img_blocks),
		.cmd        (cmd_bus.user),
		.xfer       (xfer_bus.reply)
	);

	scsi_sector_buffer u_buffer (
		.clk         (clk),
		.rst         (rst),
		.io_ack      (io_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr  (sd_buff_wr),
		.io_lba      (io_lba),
		.io_rd       (io_rd),
		.io_wr       (io_wr),
		.sd_buff_din (sd_buff_din),
		.cmd         (cmd_bus.user),
		.xfer        (xfer_bus.buffer)
	);

endmodule

// ==== source/scsi_sector_buffer.sv ====
/*
 * sector buffers between bus and I/O controller
 * read buffer filled by the controller, write buffer filled from the bus
 * io_rd / io_wr request generation and block address
 */
`timescale 1ns/10ps

module scsi_sector_buffer (
	input  logic           clk,
	input  logic           rst,
	input  logic           io_ack,
	input  logic [8:0]     sd_buff_addr,
	input  logic [7:0]     sd_buff_dout,
	input  logic           sd_buff_wr,
	output scsi_pkg::lba_t io_lba,
	output logic           io_rd,
	output logic           io_wr,
	output logic [7:0]     sd_buff_din,
	scsi_cmd_if.user       cmd,
	scsi_xfer_if.buffer    xfer
);
	import scsi_pkg::*;

	logic [7:0] rd_buf [BLOCK_BYTES];
	logic [7:0] wr_buf [BLOCK_BYTES];
	logic       fetch_q;
	logic       store_q;
	logic       is_write;

	// read path, registered output so the buffer maps onto block ram
	always_ff @(posedge clk) begin
		if (sd_buff_wr) begin
			rd_buf[sd_buff_addr] <= sd_buff_dout;
		end
		xfer.buf_byte <= rd_buf[xfer.data_cnt[BLOCK_SHIFT-1:0]];
	end

	// write path
	always_ff @(posedge clk) begin
		if (xfer.din_stb) begin
			wr_buf[xfer.data_cnt[BLOCK_SHIFT-1:0]] <= xfer.din;
		end
		sd_buff_din <= wr_buf[sd_buff_addr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_q <= 1'b0;
			store_q <= 1'b0;
			io_rd <= 1'b0;
			io_wr <= 1'b0;
		end else begin
			fetch_q <= xfer.fetch_req;
			store_q <= xfer.store_req;
			if (io_ack) begin
				io_rd <= 1'b0;
				io_wr <= 1'b0;
			end else begin
				if (xfer.fetch_req && !fetch_q) io_rd <= 1'b1;
				if (xfer.store_req && !store_q) io_wr <= 1'b1;
			end
		end
	end

	assign xfer.io_busy = io_rd || io_wr || io_ack;

	// a write is stored after its block is in, so the counter is already one block ahead
	assign is_write = cmd.opcode inside {WRITE6, WRITE10};
	assign io_lba = cmd.lba + lba_t'(xfer.data_cnt >> BLOCK_SHIFT) -
		(is_write ? lba_t'(1) : lba_t'(0));

	a_io_exclusive: assert property (@(posedge clk) disable iff (rst) !(io_rd && io_wr))
		else $error("io_rd and io_wr requested together");

endmodule

// ==== source/scsi_reply_gen.sv ====
/*
 * reply data for the commands that answer from the target itself
 * capacity register from the mounted image size
 * inquiry, read capacity and mode sense tables
 * data out byte select between tables and sector buffer
 */
`timescale 1ns/10ps

module scsi_reply_gen (
	input logic        clk,
	input logic        img_mounted,
	input logic [23:0] img_blocks,
	scsi_cmd_if.user   cmd,
	scsi_xfer_if.reply xfer
);
	import scsi_pkg::*;

	// vendor and product as sent in inquiry bytes 8 to 31
	localparam logic [8*24-1:0] INQ_NAME = {" SEAGATE", "          ", "ST225N"};

	lba_t       capacity;
	lba_t       cap_last;
	logic [4:0] name_idx;

	always_ff @(posedge clk) begin
		if (img_mounted) begin
			capacity <= lba_t'(img_blocks) + lba_t'(CAPACITY_PAD);
		end
	end

	// read capacity reports the last block, not the count
	assign cap_last = capacity - 1'b1;
	assign name_idx = xfer.data_cnt[4:0] - 5'd8;

	always_comb begin
		xfer.out_byte = 8'h00;
		case (cmd.opcode)
			READ6, READ10: xfer.out_byte = xfer.buf_byte;
			INQUIRY: begin
				// additional length
				if (xfer.data_cnt == 4) begin
					xfer.out_byte = 8'd32;
				end else if ((xfer.data_cnt >= 8) && (xfer.data_cnt <= 31)) begin
					xfer.out_byte = INQ_NAME[191 - 8*name_idx -: 8];
				end
			end
			READ_CAPACITY: begin
				// big endian last block, then block length
				case (xfer.data_cnt)
					0: xfer.out_byte = cap_last[31:24];
					1: xfer.out_byte = cap_last[23:16];
					2: xfer.out_byte = cap_last[15:8];
					3: xfer.out_byte = cap_last[7:0];
					6: xfer.out_byte = 8'(BLOCK_BYTES >> 8);
					default: xfer.out_byte = 8'h00;
				endcase
			end
			MODE_SENSE: begin
				// header with one block descriptor
				case (xfer.data_cnt)
					3: xfer.out_byte = 8'd8;
					5: xfer.out_byte = capacity[23:16];
					6: xfer.out_byte = capacity[15:8];
					7: xfer.out_byte = capacity[7:0];
					10: xfer.out_byte = 8'(BLOCK_BYTES >> 8);
					default: xfer.out_byte = 8'h00;
				endcase
			end
			default: xfer.out_byte = 8'h00;
		endcase
	end

endmodule

// ==== source/scsi_phase_ctrl.sv ====
/*
 * bus phase state machine of the target
 * ack synchronizer and store / advance strobes
 * data byte counter, sent flags and status latch
 * bus control lines, req and data out mux
 */
`timescale 1ns/10ps

module scsi_phase_ctrl #(
	parameter int unsigned TARGET_ID = 0
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       sel,
	input  logic [7:0] din,
	input  logic       ack,
	output logic       bsy,
	output logic       msg,
	output logic       cd,
	output logic       io,
	output logic       req,
	output logic [7:0] dout,
	scsi_cmd_if.phase  cmd,
	scsi_xfer_if.phase xfer
);
	import scsi_pkg::*;

	phase_t     phase;
	phase_t     phase_q;
	status_t    status;
	logic       ack_meta;
	logic       ack_sync;
	logic       ack_prev;
	logic       stb_ack;
	logic       stb_adv;
	logic       adv_q;
	logic       hold;
	logic [7:0] din_hold;
	logic       data_complete;
	logic       status_sent;
	logic       message_sent;
	logic       is_read;
	logic       is_write;
	logic       blk_start;

	// ack is asynchronous, store two cycles after it is seen and advance one later
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_meta <= 1'b0;
			ack_sync <= 1'b0;
			ack_prev <= 1'b0;
			stb_ack <= 1'b0;
			stb_adv <= 1'b0;
			adv_q <= 1'b0;
		end else begin
			ack_meta <= ack;
			ack_sync <= ack_meta;
			ack_prev <= ack_sync;
			stb_ack <= ack_sync & ~ack_prev;
			stb_adv <= stb_ack;
			adv_q <= stb_adv;
		end
	end

	// initiator holds data while ack is up
	always_ff @(posedge clk) begin
		if (ack) begin
			din_hold <= din;
		end
	end

	assign cmd.cmd_byte = din_hold;
	assign cmd.cmd_stb = stb_ack && (phase == CMD_IN);
	assign cmd.cmd_clr = (phase == IDLE);
	assign xfer.din = din_hold;
	assign xfer.din_stb = stb_ack && (phase == DATA_IN);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= IDLE;
			phase_q <= IDLE;
			status <= GOOD;
		end else begin
			phase_q <= phase;
			case (phase)
				// own id on the data lines during selection
				IDLE: if (sel && din[TARGET_ID]) phase <= CMD_IN;
				CMD_IN: if (cmd.cmd_done) begin
					status <= cmd.cmd_known ? GOOD : CHECK_CONDITION;
					if (!cmd.cmd_known || (cmd.kind == NONE) || (cmd.data_len == '0)) begin
						phase <= STATUS_OUT;
					end else if (cmd.kind == TO_INITIATOR) begin
						phase <= DATA_OUT;
					end else begin
						phase <= DATA_IN;
					end
				end
				DATA_OUT, DATA_IN: if (data_complete) phase <= STATUS_OUT;
				STATUS_OUT: if (status_sent) phase <= MESSAGE_OUT;
				MESSAGE_OUT: if (message_sent) phase <= IDLE;
				default: phase <= IDLE;
			endcase
		end
	end

	// counter holds through status and message so io_lba stays put for the last write
	always_ff @(posedge clk) begin
		if (rst || (phase inside {IDLE, CMD_IN})) begin
			xfer.data_cnt <= '0;
			data_complete <= 1'b0;
		end else if (stb_adv && !data_complete && (phase inside {DATA_OUT, DATA_IN})) begin
			xfer.data_cnt <= xfer.data_cnt + 1'b1;
			data_complete <= (xfer.data_cnt == (cmd.data_len - 1'b1));
		end
	end

	always_ff @(posedge clk) begin
		if (rst || (phase != STATUS_OUT)) begin
			status_sent <= 1'b0;
		end else if (stb_adv) begin
			status_sent <= 1'b1;
		end
		if (rst || (phase != MESSAGE_OUT)) begin
			message_sent <= 1'b0;
		end else if (stb_adv) begin
			message_sent <= 1'b1;
		end
	end

	// block requests towards the buffer
	assign is_read = cmd.opcode inside {READ6, READ10};
	assign is_write = cmd.opcode inside {WRITE6, WRITE10};
	assign blk_start = (xfer.data_cnt[BLOCK_SHIFT-1:0] == '0);
	assign xfer.fetch_req = (phase == DATA_OUT) && is_read && blk_start && !data_complete;
	// a full block written, or the final one once status is reached
	assign xfer.store_req = is_write && (((phase == DATA_IN) && blk_start &&
		(xfer.data_cnt != '0)) || (phase == STATUS_OUT));

	assign bsy = (phase != IDLE);
	assign msg = (phase == MESSAGE_OUT);
	assign cd = phase inside {CMD_IN, STATUS_OUT, MESSAGE_OUT};
	assign io = phase inside {DATA_OUT, STATUS_OUT, MESSAGE_OUT};

	// keep req low from ack until the byte is taken and the next one has settled
	assign hold = ack || ack_meta || ack_sync || stb_ack || stb_adv || adv_q ||
		(phase != phase_q);
	assign req = bsy && !hold && !xfer.io_busy;

	always_comb begin
		case (phase)
			STATUS_OUT: dout = status;
			MESSAGE_OUT: dout = MSG_CMD_COMPLETE;
			DATA_OUT: dout = xfer.out_byte;
			default: dout = 8'h00;
		endcase
	end

	// a new block request is picked up by the buffer before req can rise
	a_req_waits_io: assert property (@(posedge clk) disable iff (rst)
		($rose(xfer.fetch_req) || $rose(xfer.store_req)) |-> !req ##1 (xfer.io_busy && !req))
		else $error("req raised while a block request was pending");

endmodule

// ==== source/scsi_cmd_decoder.sv ====
/*
 * command descriptor block decoder
 * collects six or ten command bytes, detects completion by opcode group
 * latches block address and length, derives kind and data length
 */
`timescale 1ns/10ps

module scsi_cmd_decoder (
	input logic         clk,
	input logic         rst,
	scsi_cmd_if.decoder cmd
);
	import scsi_pkg::*;

	logic [7:0]  cmd_mem [10];
	logic [3:0]  cmd_idx;
	logic [2:0]  group;
	logic        cpl;
	logic        is_rw;
	logic [15:0] len6;
	logic [15:0] len10;
	logic [15:0] tlen;
	lba_t        lba6;
	lba_t        lba10;

	assign cmd.opcode = opcode_t'(cmd_mem[0]);
	assign group = cmd_mem[0][7:5];
	// group 0 is six bytes, groups 1 and 2 are ten
	assign cpl = ((group == 3'd0) && (cmd_idx == 4'd6)) ||
		((group inside {3'd1, 3'd2}) && (cmd_idx == 4'd10));
	assign is_rw = cmd.opcode inside {READ6, WRITE6, READ10, WRITE10};

	// field layout of the two block formats
	assign lba6 = {11'd0, cmd_mem[1][4:0], cmd_mem[2], cmd_mem[3]};
	assign lba10 = {cmd_mem[2], cmd_mem[3], cmd_mem[4], cmd_mem[5]};
	// zero blocks in a six byte read or write means 256
	assign len6 = (is_rw && (cmd_mem[4] == 8'd0)) ? 16'd256 : {8'd0, cmd_mem[4]};
	assign len10 = {cmd_mem[7], cmd_mem[8]};

	always_ff @(posedge clk) begin
		if (cmd.cmd_stb && (cmd_idx < 4'd10)) begin
			cmd_mem[cmd_idx] <= cmd.cmd_byte;
		end
		// take the fields once, on the cycle the block completes
		if (cpl && !cmd.cmd_done) begin
			cmd.lba <= (group == 3'd0) ? lba6 : lba10;
			tlen <= (group == 3'd0) ? len6 : len10;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || cmd.cmd_clr) begin
			cmd_idx <= 4'd0;
			cmd.cmd_done <= 1'b0;
		end else begin
			if (cmd.cmd_stb && (cmd_idx < 4'd10)) begin
				cmd_idx <= cmd_idx + 4'd1;
			end
			cmd.cmd_done <= cpl;
		end
	end

	always_comb begin
		cmd.kind = NONE;
		cmd.cmd_known = 1'b1;
		case (cmd.opcode)
			READ6, READ10, INQUIRY, READ_CAPACITY, MODE_SENSE: cmd.kind = TO_INITIATOR;
			WRITE6, WRITE10, MODE_SELECT: cmd.kind = FROM_INITIATOR;
			TEST_UNIT_READY, FORMAT: cmd.kind = NONE;
			default: cmd.cmd_known = 1'b0;
		endcase
	end

	// read capacity is fixed, block commands count sectors, the rest count bytes
	always_comb begin
		if (cmd.opcode == READ_CAPACITY) begin
			cmd.data_len = byte_cnt_t'(8);
		end else if (is_rw) begin
			cmd.data_len = byte_cnt_t'(tlen) << BLOCK_SHIFT;
		end else begin
			cmd.data_len = byte_cnt_t'(tlen);
		end
	end

	// the phase controller leaves command in once ten bytes are held
	a_cmd_idx_range: assert property (@(posedge clk) disable iff (rst)
		cmd.cmd_stb |-> (cmd_idx < 4'd10))
		else $error("command byte strobe with a full command buffer");

endmodule

// ==== source/scsi_xfer_if.sv ====
/*
 * data phase path between phase controller, sector buffer and reply tables
 * byte counter, stored byte strobe, block request and busy
 */
`timescale 1ns/10ps

interface scsi_xfer_if;
	import scsi_pkg::*;

	byte_cnt_t  data_cnt;
	logic       din_stb;
	logic [7:0] din;
	// level requests, the buffer turns their rising edge into io_rd / io_wr
	logic       fetch_req;
	logic       store_req;
	logic       io_busy;
	logic [7:0] buf_byte;
	// byte shown to the initiator in data out
	logic [7:0] out_byte;

	modport phase (output data_cnt, din_stb, din, fetch_req, store_req,
		input io_busy, out_byte);
	modport buffer (input data_cnt, din_stb, din, fetch_req, store_req,
		output io_busy, buf_byte);
	modport reply (input data_cnt, buf_byte, output out_byte);

endinterface

// ==== source/scsi_cmd_if.sv ====
/*
 * command path between phase controller and decoder
 * raw command bytes with store strobe and clear
 * decoded opcode, transfer kind, block address and data length
 */
`timescale 1ns/10ps

interface scsi_cmd_if;
	import scsi_pkg::*;

	logic [7:0] cmd_byte;
	logic       cmd_stb;
	logic       cmd_clr;

	// decoded fields, valid while cmd_done is high
	logic       cmd_done;
	logic       cmd_known;
	opcode_t    opcode;
	xfer_kind_t kind;
	lba_t       lba;
	byte_cnt_t  data_len;

	modport phase (output cmd_byte, cmd_stb, cmd_clr,
		input cmd_done, cmd_known, opcode, kind, data_len);
	modport decoder (input cmd_byte, cmd_stb, cmd_clr,
		output cmd_done, cmd_known, opcode, kind, lba, data_len);
	// data side blocks only look at the command and its address
	modport user (input opcode, lba);

endinterface

// ==== source/scsi_pkg.sv ====
/*
 * shared definitions for the scsi disk target
 * bus phase, opcode, transfer kind and status enums
 * message code, block geometry and capacity padding
 * block address and byte counter types
 */
package scsi_pkg;

	// bus phase as seen by the initiator, data out is target to initiator
	typedef enum logic [2:0] {
		IDLE,
		CMD_IN,
		DATA_OUT,
		DATA_IN,
		STATUS_OUT,
		MESSAGE_OUT
	} phase_t;

	// supported command opcodes, anything else is reported as check condition
	typedef enum logic [7:0] {
		TEST_UNIT_READY = 8'h00,
		FORMAT          = 8'h04,
		READ6           = 8'h08,
		WRITE6          = 8'h0a,
		INQUIRY         = 8'h12,
		MODE_SELECT     = 8'h15,
		MODE_SENSE      = 8'h1a,
		READ_CAPACITY   = 8'h25,
		READ10          = 8'h28,
		WRITE10         = 8'h2a
	} opcode_t;

	// direction of the data phase a command needs
	typedef enum logic [1:0] {
		NONE,
		TO_INITIATOR,
		FROM_INITIATOR
	} xfer_kind_t;

	typedef enum logic [7:0] {
		GOOD            = 8'h00,
		CHECK_CONDITION = 8'h02
	} status_t;

	localparam logic [7:0] MSG_CMD_COMPLETE = 8'h00;

	// one sector per block
	localparam int BLOCK_BYTES = 512;
	localparam int BLOCK_SHIFT = 9;
	// blocks reported on top of the mounted image size
	localparam int CAPACITY_PAD = 96;

	typedef logic [31:0] lba_t;
	typedef logic [31:0] byte_cnt_t;

endpackage
